// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_pass_b = 3'd5
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_sel_e;

    // Writeback source select
    typedef enum logic [1:0] {
        wb_mem      = 2'd0,
        wb_alu      = 2'd1,
        wb_pc_plus4 = 2'd2
    } wb_sel_e;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef struct packed {
        logic     a_sel;
        logic     b_sel;
        alu_op_e  alu_op;
        logic     mem_wr;
        logic     reg_wen;
        imm_sel_e imm_sel;
        logic     br_un;
        logic     pc_sel;
        wb_sel_e  wb_sel;
    } ctl_t;

endpackage

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    pc_sel,
    input  wire logic [rv_pkg::XLEN-1:0] target,
    output logic      [rv_pkg::XLEN-1:0] pc,
    output logic      [rv_pkg::XLEN-1:0] pc_plus4
);

    import rv_pkg::*;

    logic [XLEN-1:0] next_pc;

    assign pc_plus4 = pc + 32'd4;

    // Bit 0 cleared for JALR, a no-op for the other targets
    assign next_pc = pc_sel ? {target[XLEN-1:1], 1'b0} : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: source/instr_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module instr_ctl (
    input  wire logic [31:0]  instruction,
    input  wire logic         br_eq,
    input  wire logic         br_lt,
    output rv_pkg::ctl_t      ctl
);

    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;

    assign opcode    = opcode_e'(instruction[6:0]);
    assign funct3    = instruction[14:12];
    assign funct7_b5 = instruction[30];

    always_comb begin
        // No-op unless a supported encoding matches below
        ctl = '{a_sel: 1'b0, b_sel: 1'b0, alu_op: alu_add, mem_wr: 1'b0,
                reg_wen: 1'b0, imm_sel: imm_i, br_un: 1'b0, pc_sel: 1'b0,
                wb_sel: wb_alu};
        case (opcode)
            op_lui: begin
                ctl.b_sel   = 1'b1;
                ctl.alu_op  = alu_pass_b;
                ctl.imm_sel = imm_u;
                ctl.reg_wen = 1'b1;
            end
            op_auipc: begin
                ctl.a_sel   = 1'b1;
                ctl.b_sel   = 1'b1;
                ctl.imm_sel = imm_u;
                ctl.reg_wen = 1'b1;
            end
            op_jal: begin
                ctl.a_sel   = 1'b1;
                ctl.b_sel   = 1'b1;
                ctl.imm_sel = imm_j;
                ctl.reg_wen = 1'b1;
                ctl.pc_sel  = 1'b1;
                ctl.wb_sel  = wb_pc_plus4;
            end
            op_jalr: begin
                ctl.b_sel   = 1'b1;
                ctl.reg_wen = 1'b1;
                ctl.pc_sel  = 1'b1;
                ctl.wb_sel  = wb_pc_plus4;
            end
            op_branch: begin
                // Target is pc + B immediate
                ctl.a_sel   = 1'b1;
                ctl.b_sel   = 1'b1;
                ctl.imm_sel = imm_b;
                case (funct3)
                    3'b000: ctl.pc_sel = br_eq;
                    3'b001: ctl.pc_sel = ~br_eq;
                    3'b100: ctl.pc_sel = br_lt;
                    3'b101: ctl.pc_sel = ~br_lt;
                    3'b110: begin
                        ctl.br_un  = 1'b1;
                        ctl.pc_sel = br_lt;
                    end
                    3'b111: begin
                        ctl.br_un  = 1'b1;
                        ctl.pc_sel = ~br_lt;
                    end
                    default: ctl.pc_sel = 1'b0;
                endcase
            end
            op_load: begin
                if (funct3 == 3'b010) begin
                    ctl.b_sel   = 1'b1;
                    ctl.reg_wen = 1'b1;
                    ctl.wb_sel  = wb_mem;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    ctl.b_sel   = 1'b1;
                    ctl.imm_sel = imm_s;
                    ctl.mem_wr  = 1'b1;
                end
            end
            op_imm: begin
                // ADDI only
                if (funct3 == 3'b000) begin
                    ctl.b_sel   = 1'b1;
                    ctl.reg_wen = 1'b1;
                end
            end
            op_reg: begin
                ctl.reg_wen = 1'b1;
                case (funct3)
                    3'b000:  ctl.alu_op = funct7_b5 ? alu_sub : alu_add;
                    3'b100:  ctl.alu_op = alu_xor;
                    3'b110:  ctl.alu_op = alu_or;
                    3'b111:  ctl.alu_op = alu_and;
                    default: ctl.reg_wen = 1'b0;
                endcase
            end
            default: ctl.reg_wen = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
    input  wire logic [31:0]        instruction,
    input  wire rv_pkg::imm_sel_e   imm_sel,
    output logic [rv_pkg::XLEN-1:0] imm
);

    import rv_pkg::*;

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        case (imm_sel)
            imm_s: imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            imm_b: imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                          instruction[11:8], 1'b0};
            imm_u: imm = {instruction[31:12], 12'b0};
            imm_j: imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                          instruction[30:21], 1'b0};
            // I format also covers loads and JALR
            default: imm = {{20{sign}}, instruction[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic [4:0]              rs1_addr,
    input  wire logic [4:0]              rs2_addr,
    input  wire logic [4:0]              rd_addr,
    input  wire logic                    wen,
    input  wire logic [rv_pkg::XLEN-1:0] rd_data,
    output logic      [rv_pkg::XLEN-1:0] rs1_data,
    output logic      [rv_pkg::XLEN-1:0] rs2_data
);

    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: source/alu_branch.sv
`timescale 1ns/10ps
`default_nettype none

module alu_branch (
    input  wire logic [rv_pkg::XLEN-1:0] a,
    input  wire logic [rv_pkg::XLEN-1:0] b,
    input  wire logic [rv_pkg::XLEN-1:0] rs1,
    input  wire logic [rv_pkg::XLEN-1:0] rs2,
    input  wire rv_pkg::alu_op_e         alu_op,
    input  wire logic                    br_un,
    output logic      [rv_pkg::XLEN-1:0] result,
    output logic                         br_eq,
    output logic                         br_lt
);

    import rv_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    always_comb begin
        case (alu_op)
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    // Comparator uses the register values rather than the ALU operands
    assign lt_signed   = $signed(rs1) < $signed(rs2);
    assign lt_unsigned = rs1 < rs2;

    assign br_eq = (rs1 == rs2);
    assign br_lt = br_un ? lt_unsigned : lt_signed;

endmodule

`default_nettype wire

// File: source/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem #(
    parameter int DMEM_WORDS = 64
) (
    input  wire logic                    clk,
    input  wire logic [rv_pkg::XLEN-1:0] addr,
    input  wire logic [rv_pkg::XLEN-1:0] wdata,
    input  wire logic                    wr,
    output logic      [rv_pkg::XLEN-1:0] rdata
);

    import rv_pkg::*;

    localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [29:0]     word_addr;
    logic [AW-1:0]   idx;

    // Word index wraps at the memory depth
    assign word_addr = addr[31:2] % 30'(DMEM_WORDS);
    assign idx       = word_addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
    parameter logic [31:0] RESET_PC   = 32'h0000_0000,
    parameter int          DMEM_WORDS = 64
) (
    input  wire logic        clk,
    input  wire logic        reset,
    output logic      [31:0] pc,
    input  wire logic [31:0] instr,
    output logic             wb_en,
    output logic      [4:0]  wb_rd,
    output logic      [31:0] wb_data,
    output logic             st_en,
    output logic      [31:0] st_addr,
    output logic      [31:0] st_data
);

    import rv_pkg::*;

    ctl_t            ctl;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;
    logic            br_eq;
    logic            br_lt;

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_i (
        .clk(clk), .reset(reset), .pc_sel(ctl.pc_sel), .target(alu_result),
        .pc(pc), .pc_plus4(pc_plus4)
    );

    instr_ctl ctl_i (
        .instruction(instr), .br_eq(br_eq), .br_lt(br_lt), .ctl(ctl)
    );

    imm_gen imm_i (
        .instruction(instr), .imm_sel(ctl.imm_sel), .imm(imm)
    );

    reg_file rf_i (
        .clk(clk), .reset(reset), .rs1_addr(instr[19:15]), .rs2_addr(instr[24:20]),
        .rd_addr(instr[11:7]), .wen(wb_en), .rd_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    assign alu_a = ctl.a_sel ? pc : rs1_data;
    assign alu_b = ctl.b_sel ? imm : rs2_data;

    alu_branch alu_i (
        .a(alu_a), .b(alu_b), .rs1(rs1_data), .rs2(rs2_data), .alu_op(ctl.alu_op),
        .br_un(ctl.br_un), .result(alu_result), .br_eq(br_eq), .br_lt(br_lt)
    );

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) dmem_i (
        .clk(clk), .addr(alu_result), .wdata(rs2_data), .wr(st_en), .rdata(load_data)
    );

    always_comb begin
        case (ctl.wb_sel)
            wb_mem:      wb_data = load_data;
            wb_pc_plus4: wb_data = pc_plus4;
            default:     wb_data = alu_result;
        endcase
    end

    // Strobes held low during reset
    assign wb_en   = ctl.reg_wen & ~reset;
    assign wb_rd   = instr[11:7];
    assign st_en   = ctl.mem_wr & ~reset;
    assign st_addr = alu_result;
    assign st_data = rs2_data;

endmodule

`default_nettype wire

// File: sim/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    localparam int          PERIOD       = 40;
    localparam int          RESET_CYCLES = 16;
    localparam int          DMEM_WORDS   = 64;
    localparam logic [31:0] RESET_PC     = 32'h0000_0000;
    localparam int          N_ALU        = 200;
    localparam int          N_UPPER      = 100;
    localparam int          N_BRANCH     = 200;
    localparam int          N_JUMP       = 100;
    localparam int          N_MEM        = 200;
    localparam int          N_ILLEGAL    = 100;
    localparam int          MAX_CYCLES   = RESET_CYCLES + N_ALU + N_UPPER + N_BRANCH + N_JUMP
                                           + N_MEM + N_ILLEGAL + 100;

    typedef struct packed {
        logic        wb_en;
        logic [4:0]  wb_rd;
        logic [31:0] wb_data;
        logic        st_en;
        logic [31:0] st_addr;
        logic [31:0] st_data;
        logic [31:0] next_pc;
    } expect_t;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        st_en;
    logic [31:0] st_addr;
    logic [31:0] st_data;

    // Reference model state
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [DMEM_WORDS];
    bit          m_stored [DMEM_WORDS];
    logic [31:0] m_pc;

    integer seed;
    int     test_errors;
    int     total_errors;
    int     tests_failed;
    int     cycle_count;

    rv_core #(.RESET_PC(RESET_PC), .DMEM_WORDS(DMEM_WORDS)) dut_i (
        .clk(clk), .reset(reset), .pc(pc), .instr(instr), .wb_en(wb_en), .wb_rd(wb_rd),
        .wb_data(wb_data), .st_en(st_en), .st_addr(st_addr), .st_data(st_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic bit is_supported(input logic [6:0] op);
        case (op)
            7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Random instruction of the class that a test exercises
    function automatic logic [31:0] make_instr(input int kind);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  op;
        int unsigned pick;
        int unsigned idx;
        r    = rand_word();
        rd   = r[11:7];
        rs1  = r[19:15];
        rs2  = r[24:20];
        pick = rand_below(6);
        idx  = rand_below(16);
        case (kind)
            1: begin
                case (pick)
                    0: return {r[31:20], rs1, 3'b000, rd, 7'h13};
                    1: return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
                    2: return {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
                    3: return {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
                    4: return {7'h00, rs2, rs1, 3'b110, rd, 7'h33};
                    default: return {7'h00, rs2, rs1, 3'b100, rd, 7'h33};
                endcase
            end
            2: return {r[31:12], rd, (pick[0] ? 7'h17 : 7'h37)};
            3: begin
                // Equal operands now and then so ties get covered
                if (pick == 0) begin
                    rs2 = rs1;
                end
                f3 = (idx % 6 < 2) ? 3'(idx % 6) : 3'(idx % 6 + 2);
                return {r[31:25], rs2, rs1, f3, r[11:7], 7'h63};
            end
            4: begin
                if (pick < 3) begin
                    return {r[31:12], rd, 7'h6f};
                end
                return {r[31:20], rs1, 3'b000, rd, 7'h67};
            end
            5: begin
                // Word addresses built on x0 and loads only from stored words
                if (pick < 2 || (pick < 4 && !m_stored[idx])) begin
                    return {7'(idx >> 3), rs2, 5'd0, 3'b010, 5'(idx << 2), 7'h23};
                end else if (pick < 4) begin
                    return {12'(idx << 2), 5'd0, 3'b010, rd, 7'h03};
                end
                return {r[31:20], rs1, 3'b000, rd, 7'h13};
            end
            default: begin
                op = r[6:0];
                while (is_supported(op)) begin
                    r  = rand_word();
                    op = r[6:0];
                end
                return {r[31:7], op};
            end
        endcase
    endfunction

    // ISA rules applied to the model state
    function automatic expect_t predict(input logic [31:0] ins);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        take;
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        e     = '0;
        e.wb_rd   = ins[11:7];
        e.next_pc = m_pc + 32'd4;
        case (ins[6:0])
            7'h37: begin
                e.wb_en   = 1'b1;
                e.wb_data = imm_u;
            end
            7'h17: begin
                e.wb_en   = 1'b1;
                e.wb_data = m_pc + imm_u;
            end
            7'h6f: begin
                e.wb_en   = 1'b1;
                e.wb_data = m_pc + 32'd4;
                e.next_pc = m_pc + imm_j;
            end
            7'h67: begin
                e.wb_en   = 1'b1;
                e.wb_data = m_pc + 32'd4;
                e.next_pc = (a + imm_i) & 32'hffff_fffe;
            end
            7'h63: begin
                case (ins[14:12])
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    e.next_pc = m_pc + imm_b;
                end
            end
            7'h03: begin
                if (ins[14:12] == 3'b010) begin
                    e.wb_en   = 1'b1;
                    e.wb_data = m_mem[((a + imm_i) >> 2) % DMEM_WORDS];
                end
            end
            7'h23: begin
                if (ins[14:12] == 3'b010) begin
                    e.st_en   = 1'b1;
                    e.st_addr = a + imm_s;
                    e.st_data = b;
                end
            end
            7'h13: begin
                e.wb_en   = (ins[14:12] == 3'b000);
                e.wb_data = a + imm_i;
            end
            7'h33: begin
                e.wb_en = 1'b1;
                case (ins[14:12])
                    3'b000:  e.wb_data = ins[30] ? a - b : a + b;
                    3'b100:  e.wb_data = a ^ b;
                    3'b110:  e.wb_data = a | b;
                    3'b111:  e.wb_data = a & b;
                    default: e.wb_en = 1'b0;
                endcase
            end
            default: e.wb_en = 1'b0;
        endcase
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_val("pc", pc, m_pc);
        check_val("wb_en", 32'(wb_en), 32'(e.wb_en));
        if (e.wb_en) begin
            check_val("wb_rd", 32'(wb_rd), 32'(e.wb_rd));
            check_val("wb_data", wb_data, e.wb_data);
        end
        check_val("st_en", 32'(st_en), 32'(e.st_en));
        if (e.st_en) begin
            check_val("st_addr", st_addr, e.st_addr);
            check_val("st_data", st_data, e.st_data);
        end
    endtask

    task automatic commit(input expect_t e);
        // x0 stays zero in the model
        if (e.wb_en && e.wb_rd != 5'd0) begin
            m_regs[e.wb_rd] = e.wb_data;
        end
        if (e.st_en) begin
            m_mem[(e.st_addr >> 2) % DMEM_WORDS]    = e.st_data;
            m_stored[(e.st_addr >> 2) % DMEM_WORDS] = 1'b1;
        end
        m_pc = e.next_pc;
    endtask

    task automatic report_test(input int num, input string name, input int count);
        if (test_errors == 0) begin
            $display("test %0d (%s): %0d instructions, ok", num, name, count);
        end else begin
            $display("test %0d (%s): %0d instructions, %0d errors", num, name, count,
                     test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    // PC held and both strobes masked whatever instruction arrives in reset
    task automatic hold_reset(input int cycles);
        int kind;
        test_errors = 0;
        @(posedge clk);
        for (int n = 0; n < cycles - 1; n++) begin
            @(negedge clk);
            kind  = (n % 3 == 0) ? 1 : ((n % 3 == 1) ? 4 : 5);
            instr = make_instr(kind);
            #(PERIOD / 4);
            check_val("pc", pc, RESET_PC);
            check_val("wb_en", 32'(wb_en), 32'd0);
            check_val("st_en", 32'(st_en), 32'd0);
        end
        @(negedge clk);
        reset = 1'b0;
        report_test(0, "reset", cycles - 1);
    endtask

    // Drives on a falling edge and samples a quarter period later
    task automatic run_test(input int kind, input int count, input string name);
        logic [31:0] ins;
        expect_t     e;
        test_errors = 0;
        for (int n = 0; n < count; n++) begin
            ins   = make_instr(kind);
            instr = ins;
            e     = predict(ins);
            #(PERIOD / 4);
            check_outputs(e);
            commit(e);
            @(negedge clk);
        end
        report_test(kind, name, count);
    endtask

    initial begin
        seed         = 84;
        reset        = 1'b1;
        instr        = 32'h0000_0000;
        test_errors  = 0;
        total_errors = 0;
        tests_failed = 0;
        m_pc         = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            m_stored[i] = 1'b0;
        end
        hold_reset(RESET_CYCLES);
        run_test(1, N_ALU, "register and immediate ALU ops");
        run_test(2, N_UPPER, "LUI and AUIPC");
        run_test(3, N_BRANCH, "branches");
        run_test(4, N_JUMP, "JAL and JALR");
        run_test(5, N_MEM, "SW and LW");
        run_test(6, N_ILLEGAL, "unsupported opcodes");
        $display("%0d of 7 tests failed, %0d errors in total", tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
source/rv_pkg.sv
source/fetch_unit.sv
source/instr_ctl.sv
source/imm_gen.sv
source/reg_file.sv
source/alu_branch.sv
source/data_mem.sv
source/rv_core.sv
sim/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_rv_core -o tb_rv_core > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
